/* design/sublane_cfg_pkg.sv */
package sublane_cfg_pkg;

   ////////////////////////////////////////////////////////////
   // array and VRF sizes
   localparam int VLANE_NUM_DEF   = 8;     // power of two
   localparam int MEM_DEPTH       = 512;   // VRF words per lane
   localparam int MAX_VL_PER_LANE = 256;

   typedef logic [$clog2(MEM_DEPTH)-1:0]                     vrf_addr_t;
   typedef logic [$clog2(MAX_VL_PER_LANE):0]                 elem_cnt_t; // holds the max itself
   typedef logic [$clog2(VLANE_NUM_DEF*MAX_VL_PER_LANE)-1:0] vl_t;
   typedef logic [1:0]                                       sew_t;
   typedef logic [3:0]                                       bwen_t;
   typedef logic [7:0]                                       delay_t;
   typedef logic [1:0]                                       bpos_t;     // element slot in a word

   localparam sew_t SEW_BYTE = 2'd0;
   localparam sew_t SEW_HALF = 2'd1;
   localparam sew_t SEW_WORD = 2'd2;

   // true on the last element slot of a 32-bit word
   function automatic logic last_in_word(sew_t sew, bpos_t pos);
      case (sew)
         SEW_BYTE: return pos == 2'd3;
         SEW_HALF: return pos == 2'd1;
         default:  return 1'b1;
      endcase
   endfunction

endpackage

/* design/sublane_ctrl_pkg.sv */
package sublane_ctrl_pkg;

   typedef enum logic [1:0] {
      NORMAL,
      STORE,
      LOAD
   } inst_kind_e;

   typedef enum logic [2:0] {
      IDLE,
      LATCH,          // instruction held, limit being computed
      NORMAL_MODE,
      STORE_MODE,
      LOAD_MODE
   } driver_state_e;

   // instruction as held for the whole run
   typedef struct packed {
      inst_kind_e                       kind;
      sublane_cfg_pkg::sew_t            sew;
      sublane_cfg_pkg::vl_t             vl;
      sublane_cfg_pkg::delay_t          inst_delay;
      sublane_cfg_pkg::vrf_addr_t       waddr_start;
      sublane_cfg_pkg::vrf_addr_t [1:0] raddr_start;  // vs1, vs2
   } sublane_inst_t;

   // one VRF write beat, shared by all lanes
   typedef struct packed {
      logic                       wen;
      sublane_cfg_pkg::vrf_addr_t waddr;
      sublane_cfg_pkg::bwen_t     bwen;
   } vrf_wr_t;

endpackage

/* design/element_counter.sv */
`timescale 1ns/1ps

module element_counter (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       clr_i,
   input  logic                       en_i,
   output sublane_cfg_pkg::elem_cnt_t count_o
);
   import sublane_cfg_pkg::*;

   localparam elem_cnt_t CNT_MAX = '1;

   logic at_max;

   assign at_max = (count_o == CNT_MAX);

   // saturates instead of wrapping, so a long delay never restarts a phase
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         count_o <= '0;
      end else if (clr_i) begin
         count_o <= '0;
      end else if (en_i && !at_max) begin
         count_o <= count_o + 1'b1;
      end
   end

endmodule

/* design/sublane_fsm.sv */
`timescale 1ns/1ps

module sublane_fsm #(
   parameter int VLANE_NUM = sublane_cfg_pkg::VLANE_NUM_DEF
) (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           start_i,
   input  sublane_ctrl_pkg::sublane_inst_t inst_i,
   input  logic                           load_valid_i,
   input  logic                           load_last_i,
   input  sublane_cfg_pkg::elem_cnt_t     count_i,
   output logic                           cnt_clr_o,
   output logic                           cnt_en_o,
   output sublane_ctrl_pkg::sublane_inst_t inst_o,
   output logic                           rd_load_o,
   output logic                           rd_step_o,
   output sublane_cfg_pkg::sew_t          rd_sew_o,
   output logic                           wr_load_o,
   output logic                           wr_step_o,
   output logic                           wr_from_load_o,
   output logic                           ready_o,
   output logic                           ready_for_load_o,
   output logic                           store_data_valid_o
);
   import sublane_cfg_pkg::*;
   import sublane_ctrl_pkg::*;

   localparam int LANE_SHIFT = $clog2(VLANE_NUM);

   driver_state_e state_q, state_d;
   sublane_inst_t inst_q;
   elem_cnt_t     lim_q;        // elements per lane
   elem_cnt_t     lane_limit;
   elem_cnt_t     delay_cnt;
   elem_cnt_t     end_cnt;
   logic          accept;
   logic          rd_phase;
   logic          wr_phase;
   logic          rem_nz;

   ////////////////////////////////////////////////////////////
   // phase boundaries
   assign accept     = (state_q == IDLE) && start_i && ready_o;
   assign rem_nz     = (inst_q.vl & vl_t'(VLANE_NUM - 1)) != '0;
   assign lane_limit = elem_cnt_t'(inst_q.vl >> LANE_SHIFT) + elem_cnt_t'(rem_nz);
   assign delay_cnt  = elem_cnt_t'(inst_q.inst_delay);
   assign end_cnt    = delay_cnt + lim_q;   // one past the last write step
   assign rd_phase   = count_i < lim_q;
   assign wr_phase   = (count_i >= delay_cnt) && (count_i < end_cnt);

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: if (accept) state_d = LATCH;
         LATCH: begin
            case (inst_q.kind)
               NORMAL:  state_d = NORMAL_MODE;
               STORE:   state_d = STORE_MODE;
               LOAD:    state_d = LOAD_MODE;
               default: state_d = IDLE;      // unknown kind, drop it
            endcase
         end
         NORMAL_MODE: if (count_i == end_cnt) state_d = IDLE;
         STORE_MODE:  if (count_i == lim_q) state_d = IDLE;
         LOAD_MODE:   if (load_valid_i && load_last_i) state_d = IDLE;
         default:     state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_q            <= IDLE;
         ready_o            <= 1'b1;
         store_data_valid_o <= 1'b0;
      end else begin
         state_q            <= state_d;
         store_data_valid_o <= (state_q == STORE_MODE) && rd_phase; // lines up with raddr
         if (accept) begin
            ready_o <= 1'b0;
         end else if (state_q != IDLE && state_d == IDLE) begin
            ready_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) inst_q <= inst_i;
      if (state_q == LATCH) lim_q <= lane_limit;
   end

   ////////////////////////////////////////////////////////////
   // counter and port steering
   assign cnt_clr_o        = (state_q == LATCH);
   assign cnt_en_o         = (state_q == NORMAL_MODE) || (state_q == STORE_MODE);
   assign rd_load_o        = (state_q == LATCH);
   assign wr_load_o        = (state_q == LATCH);
   assign rd_step_o        = cnt_en_o && rd_phase;
   assign wr_step_o        = ((state_q == NORMAL_MODE) && wr_phase) ||
                             ((state_q == LOAD_MODE) && load_valid_i);
   assign wr_from_load_o   = (state_q == LOAD_MODE);
   assign ready_for_load_o = (state_q == LOAD_MODE);

   // store reads whole words
   assign rd_sew_o = (inst_q.kind == STORE) ? SEW_WORD : inst_q.sew;

   always_comb begin
      inst_o = inst_q;
      if (inst_q.kind == LOAD) inst_o.sew = SEW_WORD;   // one word per load beat
   end

endmodule

/* design/vrf_write_gen.sv */
`timescale 1ns/1ps

module vrf_write_gen (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  sublane_ctrl_pkg::sublane_inst_t inst_i,
   input  logic                           load_i,
   input  logic                           step_i,
   input  logic                           from_load_i,
   input  sublane_cfg_pkg::bwen_t         load_bwen_i,
   output sublane_ctrl_pkg::vrf_wr_t      vrf_wr_o
);
   import sublane_cfg_pkg::*;
   import sublane_ctrl_pkg::*;

   vrf_addr_t waddr_q;
   bpos_t     pos_q;
   bwen_t     bwen_rot;
   bwen_t     bwen_sel;
   logic      wrap;

   assign wrap = last_in_word(inst_i.sew, pos_q);

   ////////////////////////////////////////////////////////////
   // rotating byte enables
   always_comb begin
      case (inst_i.sew)
         SEW_BYTE: bwen_rot = bwen_t'(4'b0001 << pos_q);
         SEW_HALF: bwen_rot = pos_q[0] ? 4'b1100 : 4'b0011;
         default:  bwen_rot = 4'b1111;
      endcase
   end

   assign bwen_sel = from_load_i ? load_bwen_i : bwen_rot; // load unit picks its own bytes

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         pos_q <= '0;
      end else if (load_i) begin
         pos_q <= '0;
      end else if (step_i) begin
         pos_q <= wrap ? bpos_t'(0) : pos_q + 1'b1;
      end
   end

   // address moves on at each word boundary
   always_ff @(posedge clk_i) begin
      if (load_i) begin
         waddr_q <= inst_i.waddr_start;
      end else if (step_i && wrap) begin
         waddr_q <= waddr_q + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // registered beat
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         vrf_wr_o.wen <= 1'b0;
      end else begin
         vrf_wr_o.wen   <= step_i;
         vrf_wr_o.waddr <= waddr_q;
         vrf_wr_o.bwen  <= bwen_sel;
      end
   end

endmodule

/* design/vrf_read_gen.sv */
`timescale 1ns/1ps

module vrf_read_gen (
   input  logic                             clk_i,
   input  logic                             rst_i,
   input  sublane_cfg_pkg::vrf_addr_t [1:0] raddr_start_i,
   input  sublane_cfg_pkg::sew_t            sew_i,
   input  logic                             load_i,
   input  logic                             step_i,
   output sublane_cfg_pkg::vrf_addr_t [1:0] vrf_raddr_o
);
   import sublane_cfg_pkg::*;

   vrf_addr_t [1:0] raddr_q;
   bpos_t           pos_q;     // shared by both ports
   logic            wrap;

   assign wrap = last_in_word(sew_i, pos_q);

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         pos_q <= '0;
      end else if (load_i) begin
         pos_q <= '0;
      end else if (step_i) begin
         pos_q <= wrap ? bpos_t'(0) : pos_q + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      for (int i = 0; i < 2; i++) begin
         if (load_i) begin
            raddr_q[i] <= raddr_start_i[i];
         end else if (step_i && wrap) begin
            raddr_q[i] <= raddr_q[i] + 1'b1;
         end
      end
   end

   // presented one cycle after the step
   always_ff @(posedge clk_i) begin
      if (step_i) vrf_raddr_o <= raddr_q;
   end

endmodule

/* design/sublane_driver.sv */
`timescale 1ns/1ps

module sublane_driver #(
   parameter int VLANE_NUM = sublane_cfg_pkg::VLANE_NUM_DEF
) (
   input  logic                             clk_i,
   input  logic                             rst_i,
   input  logic                             start_i,
   input  sublane_ctrl_pkg::inst_kind_e     inst_kind_i,
   input  sublane_cfg_pkg::sew_t            vsew_i,
   input  sublane_cfg_pkg::vl_t             vl_i,
   input  sublane_cfg_pkg::delay_t          inst_delay_i,
   input  sublane_cfg_pkg::vrf_addr_t       vrf_waddr_start_i,
   input  sublane_cfg_pkg::vrf_addr_t [1:0] vrf_raddr_start_i,
   input  logic                             load_valid_i,
   input  logic                             load_last_i,
   input  sublane_cfg_pkg::bwen_t           load_bwen_i,
   output logic                             ready_o,
   output logic                             ready_for_load_o,
   output logic                             store_data_valid_o,
   output sublane_ctrl_pkg::vrf_wr_t        vrf_wr_o,
   output sublane_cfg_pkg::vrf_addr_t [1:0] vrf_raddr_o,
   output sublane_cfg_pkg::sew_t            vrf_read_sew_o
);
   import sublane_cfg_pkg::*;
   import sublane_ctrl_pkg::*;

   sublane_inst_t inst_in;
   sublane_inst_t inst_q;      // latched, widths already forced
   elem_cnt_t     count;
   logic          cnt_clr, cnt_en;
   logic          rd_load, rd_step;
   logic          wr_load, wr_step, wr_from_load;

   // loose inputs into one instruction word
   assign inst_in = '{kind:        inst_kind_i,
                      sew:         vsew_i,
                      vl:          vl_i,
                      inst_delay:  inst_delay_i,
                      waddr_start: vrf_waddr_start_i,
                      raddr_start: vrf_raddr_start_i};

   sublane_fsm #(.VLANE_NUM(VLANE_NUM)) u_fsm (
      .clk_i, .rst_i, .start_i,
      .inst_i(inst_in), .load_valid_i, .load_last_i, .count_i(count),
      .cnt_clr_o(cnt_clr), .cnt_en_o(cnt_en), .inst_o(inst_q),
      .rd_load_o(rd_load), .rd_step_o(rd_step), .rd_sew_o(vrf_read_sew_o),
      .wr_load_o(wr_load), .wr_step_o(wr_step), .wr_from_load_o(wr_from_load),
      .ready_o, .ready_for_load_o, .store_data_valid_o
   );

   element_counter u_cnt (
      .clk_i, .rst_i, .clr_i(cnt_clr), .en_i(cnt_en), .count_o(count)
   );

   vrf_write_gen u_wr (
      .clk_i, .rst_i, .inst_i(inst_q), .load_i(wr_load), .step_i(wr_step),
      .from_load_i(wr_from_load), .load_bwen_i, .vrf_wr_o
   );

   vrf_read_gen u_rd (
      .clk_i, .rst_i, .raddr_start_i(inst_q.raddr_start), .sew_i(vrf_read_sew_o),
      .load_i(rd_load), .step_i(rd_step), .vrf_raddr_o
   );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter real PERIOD_NS  = 4.0,
   parameter int  RST_CYCLES = 5
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b0;                     // active low
      repeat (RST_CYCLES) @(posedge clk_o);
      rst_o <= 1'b1;
   end

endmodule

/* testbench/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
   parameter int VLANE_NUM = sublane_cfg_pkg::VLANE_NUM_DEF
) (
   input  logic                             clk_i,
   input  logic                             rst_i,
   input  logic [127:0]                     test_name_i,
   input  logic                             start_i,
   input  sublane_ctrl_pkg::inst_kind_e     inst_kind_i,
   input  sublane_cfg_pkg::sew_t            vsew_i,
   input  sublane_cfg_pkg::vl_t             vl_i,
   input  sublane_cfg_pkg::delay_t          inst_delay_i,
   input  sublane_cfg_pkg::vrf_addr_t       vrf_waddr_start_i,
   input  sublane_cfg_pkg::vrf_addr_t [1:0] vrf_raddr_start_i,
   input  logic                             load_valid_i,
   input  sublane_cfg_pkg::bwen_t           load_bwen_i,
   input  logic                             ready_i,
   input  logic                             ready_for_load_i,
   input  logic                             store_data_valid_i,
   input  sublane_ctrl_pkg::vrf_wr_t        vrf_wr_i,
   input  sublane_cfg_pkg::vrf_addr_t [1:0] vrf_raddr_i,
   input  sublane_cfg_pkg::sew_t            vrf_read_sew_i,
   output int                               errors_o
);
   import sublane_cfg_pkg::*;
   import sublane_ctrl_pkg::*;

   int         cyc;
   int         acc;          // edge that took the instruction
   logic       busy;
   inst_kind_e kind;
   sew_t       sew;
   int         lim;
   int         delay;
   vrf_addr_t  wstart;
   vrf_addr_t  rstart [2];
   int         beats;
   int         sdv_cnt;
   int         load_cnt;
   bwen_t      exp_bwen_q [$];

   function automatic int elems_per_word(sew_t s);
      case (s)
         2'd0:    return 4;
         2'd1:    return 2;
         default: return 1;
      endcase
   endfunction

   task automatic err_value(string what, int exp_v, int act_v);
      $display("ERROR %0s %0s expected %0h actual %0h", test_name_i, what, exp_v, act_v);
      errors_o++;
   endtask

   task automatic err_text(string msg);
      $display("%0s: %0s", test_name_i, msg);
      errors_o++;
   endtask

   ////////////////////////////////////////////////////////////
   // one write beat against the stepping rules
   task automatic check_beat();
      int    epw;
      int    pos;
      bwen_t eb;
      epw = elems_per_word(sew);
      pos = beats % epw;
      if (kind == STORE) begin
         err_text("write beat during a store");
      end else if (kind == LOAD) begin
         if (exp_bwen_q.size() == 0) begin
            err_text("write beat with no load beat behind it");
         end else begin
            eb = exp_bwen_q.pop_front();
            if (vrf_wr_i.bwen != eb) err_value("bwen", int'(eb), int'(vrf_wr_i.bwen));
         end
         if (vrf_wr_i.waddr != vrf_addr_t'(int'(wstart) + beats))
            err_value("waddr", int'(wstart) + beats, int'(vrf_wr_i.waddr));
      end else begin
         if (beats >= lim) err_text("more write beats than elements");
         if (beats == 0 && cyc != acc + 2 + delay)
            err_value("first_beat_cycle", acc + 2 + delay, cyc);
         // bytes of one element, placed at the element's slot in the word
         eb = bwen_t'(((1 << (4 / epw)) - 1) << (pos * (4 / epw)));
         if (vrf_wr_i.bwen != eb) err_value("bwen", int'(eb), int'(vrf_wr_i.bwen));
         if (vrf_wr_i.waddr != vrf_addr_t'(int'(wstart) + beats / epw))
            err_value("waddr", int'(wstart) + beats / epw, int'(vrf_wr_i.waddr));
      end
      beats++;
   endtask

   // totals at the end of an instruction
   task automatic check_done();
      int exp_beats;
      exp_beats = (kind == NORMAL) ? lim : (kind == LOAD) ? load_cnt : 0;
      if (beats != exp_beats) err_value("beat_count", exp_beats, beats);
      if (sdv_cnt != ((kind == STORE) ? lim : 0))
         err_value("store_valid_cycles", (kind == STORE) ? lim : 0, sdv_cnt);
      if (ready_for_load_i) err_text("ready_for_load still high after the instruction");
   endtask

   always @(posedge clk_i) cyc <= cyc + 1;

   initial begin
      cyc      = 0;
      errors_o = 0;
      busy     = 1'b0;
   end

   // outputs settle well before the falling edge
   always @(negedge clk_i) begin
      int k;
      int epr;
      if (!rst_i) begin
         if (cyc > 0) begin
            if (!ready_i) err_text("ready low in reset");
            if (vrf_wr_i.wen) err_text("write enable high in reset");
            if (store_data_valid_i) err_text("store data valid high in reset");
            if (ready_for_load_i) err_text("ready_for_load high in reset");
         end
      end else begin
         if (vrf_wr_i.wen) begin
            if (!busy) err_text("write beat with no instruction running");
            else check_beat();
         end
         if (busy && kind != LOAD) begin
            k   = cyc - acc - 2;       // read step index shown now
            epr = (kind == STORE) ? 1 : elems_per_word(sew);
            if (k >= 0 && k < lim) begin
               for (int i = 0; i < 2; i++) begin
                  if (vrf_raddr_i[i] != vrf_addr_t'(int'(rstart[i]) + k / epr))
                     err_value($sformatf("raddr%0d", i), int'(rstart[i]) + k / epr,
                               int'(vrf_raddr_i[i]));
               end
            end
         end
         if (busy && store_data_valid_i) begin
            sdv_cnt++;
            if (vrf_read_sew_i != 2'd2) err_value("read_sew", 2, int'(vrf_read_sew_i));
         end
         if (busy && kind == LOAD && ready_for_load_i && load_valid_i) begin
            exp_bwen_q.push_back(load_bwen_i);
            load_cnt++;
         end
         if (busy && ready_i && cyc > acc) begin
            check_done();
            busy = 1'b0;
         end
         if (start_i && ready_i) begin
            busy      = 1'b1;
            acc       = cyc + 1;
            kind      = inst_kind_i;
            sew       = (inst_kind_i == LOAD) ? 2'd2 : vsew_i;  // load writes whole words
            lim       = (int'(vl_i) + VLANE_NUM - 1) / VLANE_NUM;
            delay     = int'(inst_delay_i);
            wstart    = vrf_waddr_start_i;
            rstart[0] = vrf_raddr_start_i[0];
            rstart[1] = vrf_raddr_start_i[1];
            beats     = 0;
            sdv_cnt   = 0;
            load_cnt  = 0;
            exp_bwen_q.delete();
         end
      end
   end

endmodule

/* testbench/tb_sublane_driver.sv */
`timescale 1ns/1ps

module tb_sublane_driver;
   import sublane_cfg_pkg::*;
   import sublane_ctrl_pkg::*;

   localparam int VLANE_NUM = 8;
   localparam int NUM_TESTS = 6;
   localparam int TIMEOUT   = 2000;

   typedef struct packed {
      logic [127:0] name;
      inst_kind_e   kind;
      sew_t         sew;
      vl_t          vl;
      delay_t       delay;
      vrf_addr_t    waddr;
      vrf_addr_t    raddr0;
      vrf_addr_t    raddr1;
      logic [7:0]   nbeats;       // load beats
      logic [7:0]   gap_pct;      // chance of an idle cycle before a beat
      logic         poke;         // extra start while busy
   } test_row_t;

   // levels the stimulus waits on
   typedef enum logic [1:0] {
      SIG_RESET,
      SIG_READY,
      SIG_LOAD_READY
   } wait_sig_e;

   logic            clk, rst;
   logic            start;
   inst_kind_e      inst_kind;
   sew_t            vsew;
   vl_t             vl;
   delay_t          inst_delay;
   vrf_addr_t       waddr_start;
   vrf_addr_t [1:0] raddr_start;
   logic            load_valid, load_last;
   bwen_t           load_bwen;
   logic            ready, ready_for_load, store_data_valid;
   vrf_wr_t         vrf_wr;
   vrf_addr_t [1:0] vrf_raddr;
   sew_t            vrf_read_sew;
   logic [127:0]    test_name;
   int              errors;
   logic            timed_out;
   test_row_t       tests [NUM_TESTS];

   tb_clock_gen #(.PERIOD_NS(4.0), .RST_CYCLES(5)) i_clock_gen (.clk_o(clk), .rst_o(rst));

   sublane_driver #(.VLANE_NUM(VLANE_NUM)) i_sublane_driver (
      .clk_i(clk), .rst_i(rst), .start_i(start),
      .inst_kind_i(inst_kind), .vsew_i(vsew), .vl_i(vl), .inst_delay_i(inst_delay),
      .vrf_waddr_start_i(waddr_start), .vrf_raddr_start_i(raddr_start),
      .load_valid_i(load_valid), .load_last_i(load_last), .load_bwen_i(load_bwen),
      .ready_o(ready), .ready_for_load_o(ready_for_load),
      .store_data_valid_o(store_data_valid),
      .vrf_wr_o(vrf_wr), .vrf_raddr_o(vrf_raddr), .vrf_read_sew_o(vrf_read_sew)
   );

   tb_checker #(.VLANE_NUM(VLANE_NUM)) i_checker (
      .clk_i(clk), .rst_i(rst), .test_name_i(test_name), .start_i(start),
      .inst_kind_i(inst_kind), .vsew_i(vsew), .vl_i(vl), .inst_delay_i(inst_delay),
      .vrf_waddr_start_i(waddr_start), .vrf_raddr_start_i(raddr_start),
      .load_valid_i(load_valid), .load_bwen_i(load_bwen),
      .ready_i(ready), .ready_for_load_i(ready_for_load),
      .store_data_valid_i(store_data_valid), .vrf_wr_i(vrf_wr),
      .vrf_raddr_i(vrf_raddr), .vrf_read_sew_i(vrf_read_sew), .errors_o(errors)
   );

   ////////////////////////////////////////////////////////////
   // bounded waits
   function automatic logic level_of(wait_sig_e s);
      case (s)
         SIG_RESET: return rst;
         SIG_READY: return ready;
         default:   return ready_for_load;
      endcase
   endfunction

   task automatic wait_level(input string what, input wait_sig_e s);
      int n;
      n = 0;
      while (!level_of(s) && !timed_out) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) begin
            $display("timed out waiting for %0s in %0s", what, test_name);
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic feed_load(test_row_t t);
      int gaps;
      for (int b = 0; b < int'(t.nbeats); b++) begin
         gaps = 0;
         while (int'($urandom % 100) < int'(t.gap_pct) && gaps < 4) begin // bounded idle run
            @(posedge clk);
            load_valid <= 1'b0;
            load_last  <= 1'b0;
            gaps++;
         end
         @(posedge clk);
         load_valid <= 1'b1;
         load_bwen  <= bwen_t'($urandom);
         load_last  <= (b == int'(t.nbeats) - 1);
      end
      @(posedge clk);
      load_valid <= 1'b0;
      load_last  <= 1'b0;
   endtask

   task automatic run_test(test_row_t t);
      wait_level("ready", SIG_READY);
      if (timed_out) return;
      @(posedge clk);
      test_name      <= t.name;
      start          <= 1'b1;
      inst_kind      <= t.kind;
      vsew           <= t.sew;
      vl             <= t.vl;
      inst_delay     <= t.delay;
      waddr_start    <= t.waddr;
      raddr_start[0] <= t.raddr0;
      raddr_start[1] <= t.raddr1;
      @(posedge clk);
      start <= 1'b0;
      if (t.poke) begin
         repeat (3) @(posedge clk);
         start <= 1'b1;               // ignored while ready is low
         @(posedge clk);
         start <= 1'b0;
      end
      if (t.kind == LOAD) begin
         wait_level("ready_for_load", SIG_LOAD_READY);
         if (timed_out) return;
         feed_load(t);
      end
      @(negedge clk);
      wait_level("ready after instruction", SIG_READY);
   endtask

   initial begin
      void'($urandom(14));
      timed_out   = 1'b0;
      start       = 1'b0;
      inst_kind   = NORMAL;
      vsew        = '0;
      vl          = '0;
      inst_delay  = '0;
      waddr_start = '0;
      raddr_start = '0;
      load_valid  = 1'b0;
      load_last   = 1'b0;
      load_bwen   = '0;
      test_name   = "reset";

      tests[0] = '{"norm_byte",  NORMAL, 2'd0, 11'd37, 8'd3, 9'd10,  9'd20,  9'd40,  8'd0, 8'd0,  1'b0};
      tests[1] = '{"norm_half",  NORMAL, 2'd1, 11'd61, 8'd6, 9'd100, 9'd200, 9'd300, 8'd0, 8'd0,  1'b0};
      tests[2] = '{"norm_word",  NORMAL, 2'd2, 11'd19, 8'd0, 9'd510, 9'd7,   9'd511, 8'd0, 8'd0,  1'b0};
      tests[3] = '{"store",      STORE,  2'd0, 11'd45, 8'd2, 9'd0,   9'd50,  9'd60,  8'd0, 8'd0,  1'b0};
      tests[4] = '{"load_gaps",  LOAD,   2'd0, 11'd8,  8'd0, 9'd300, 9'd0,   9'd0,   8'd7, 8'd40, 1'b0};
      tests[5] = '{"norm_poke",  NORMAL, 2'd1, 11'd30, 8'd4, 9'd33,  9'd1,   9'd2,   8'd0, 8'd0,  1'b1};

      wait_level("reset release", SIG_RESET);
      for (int i = 0; i < NUM_TESTS; i++) begin
         if (!timed_out) run_test(tests[i]);
      end
      repeat (4) @(negedge clk);

      $display("check errors: %0d, timeouts: %0d", errors, timed_out ? 1 : 0);
      if (timed_out || errors != 0) begin
         $display("Finished with errors");
      end else begin
         $display("Finished with no errors");
      end
      $finish;
   end

endmodule

/* all.f */
design/sublane_cfg_pkg.sv
design/sublane_ctrl_pkg.sv
design/element_counter.sv
design/sublane_fsm.sv
design/vrf_write_gen.sv
design/vrf_read_gen.sv
design/sublane_driver.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_sublane_driver.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_sublane_driver -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

# pass only when the pass line is present
echo "$out" | grep -qx "Finished with no errors"
